/* common/rf_pkg.sv */
`default_nettype none

package rf_pkg;

   localparam int ADD_W    = 5;                  // register address bits
   localparam int DATA_W   = 32;                 // register value bits
   localparam int HAM_W    = 6;                  // hamming parity bits
   localparam int CHK_W    = HAM_W + 1;          // hamming plus overall parity
   localparam int CW_W     = DATA_W + CHK_W;     // stored codeword, checksum on top
   localparam int RF_DEPTH = 32;                 // x0 .. x31

   typedef logic [ADD_W-1:0]  rf_add_t;          // 0 selects x0
   typedef logic [DATA_W-1:0] rf_val_t;
   typedef logic [CHK_W-1:0]  rf_chk_t;          // [5:0] hamming, [6] overall parity
   typedef logic [1:0]        rp_info_t;         // bit 0 read port 1, bit 1 read port 2

   // codeword position of data bit idx, positions 1..38 with parity on powers of two
   function automatic logic [HAM_W-1:0] ham_pos(input int idx);
      int cnt;
      logic [HAM_W-1:0] pos;
      cnt = 0;
      pos = '0;
      for (int p = 3; p < CW_W; p++) begin
         if ((p & (p - 1)) != 0) begin           // skip parity slots
            if (cnt == idx) pos = HAM_W'(p);
            cnt++;
         end
      end
      return pos;
   endfunction

   // parity bit j covers every data bit whose position has bit j set
   function automatic logic [HAM_W-1:0] ham_parity(input rf_val_t data);
      logic [HAM_W-1:0] par;
      logic [HAM_W-1:0] pos;
      par = '0;
      for (int i = 0; i < DATA_W; i++) begin
         pos = ham_pos(i);
         for (int j = 0; j < HAM_W; j++) begin
            if (pos[j]) par[j] = par[j] ^ data[i];
         end
      end
      return par;
   endfunction

endpackage

`default_nettype wire

/* source/secded_encode.sv */
`timescale 1ns/1ps
`default_nettype none

// SEC-DED encoder for one register value
// checksum = {overall parity, six hamming parity bits}
module secded_encode (
   input  rf_pkg::rf_val_t data_i,    // value to protect
   output rf_pkg::rf_chk_t chk_o      // checksum stored next to it
);

   logic [rf_pkg::HAM_W-1:0] ham;     // hamming part of the checksum
   logic                     ovp;     // overall parity bit

   // six parity bits over fixed bit groups
   always_comb begin
      ham = rf_pkg::ham_parity(data_i);
   end

   // overall parity spans data and hamming bits, makes the whole codeword even
   // this is what separates single from double errors in the decoder
   assign ovp = ^{data_i, ham};

   assign chk_o = {ovp, ham};         // bit 6 overall, bits 5..0 hamming

endmodule

`default_nettype wire

/* source/secded_decode.sv */
`timescale 1ns/1ps
`default_nettype none

// SEC-DED decoder, purely combinational
// corrects any single-bit error in data or checksum, flags double errors
module secded_decode (
   input  rf_pkg::rf_val_t data_i,    // stored value as read
   input  rf_pkg::rf_chk_t chk_i,     // stored checksum as read
   output rf_pkg::rf_val_t data_o,    // corrected value
   output logic            ce_o,      // correctable error seen
   output logic            uce_o      // uncorrectable error seen
);

   logic [rf_pkg::HAM_W-1:0] syn;     // syndrome, position of a single flipped bit
   logic                     par_err; // odd number of flipped bits
   logic                     syn_nz;

   // recompute hamming bits and compare against the stored ones
   always_comb begin
      syn = rf_pkg::ham_parity(data_i) ^ chk_i[rf_pkg::HAM_W-1:0];
   end

   assign syn_nz  = |syn;
   assign par_err = ^{data_i, chk_i};  // stored codeword is even when clean

   always_comb begin
      data_o = data_i;                 // pass through unless a single error hits data
      if (syn_nz && par_err) begin
         // single error, flip the data bit at the syndrome position
         // a power-of-two syndrome points at a hamming bit, nothing to flip then
         for (int i = 0; i < rf_pkg::DATA_W; i++) begin
            if (syn == rf_pkg::ham_pos(i)) data_o[i] = ~data_i[i];
         end
      end
   end

   // nonzero syndrome with odd parity: single error somewhere in the codeword
   // zero syndrome with odd parity: only the overall parity bit flipped
   assign ce_o  = par_err;
   // even parity but syndrome set: two bits flipped, data cannot be trusted
   assign uce_o = syn_nz & ~par_err;

   // both flags together would mean a broken decode
   // a correction never flips more than one data bit
   always_comb begin
      assert (!(ce_o && uce_o) && ($countones(data_o ^ data_i) <= 1))
         else $error("secded_decode: ce with uce, or more than one bit corrected");
   end

endmodule

`default_nettype wire

/* regfile/rf_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

// storage for 32 protected registers, codeword = {checksum, data}
// one synchronous write port, two combinational read ports
module rf_data_array (
   input  wire                          s_clk_i,
   input  wire                          we_i,          // write enable
   input  rf_pkg::rf_add_t              w_add_i,       // write address
   input  rf_pkg::rf_val_t              w_val_i,       // write data
   input  rf_pkg::rf_chk_t              w_chk_i,       // write checksum
   input  rf_pkg::rf_add_t              r1_add_i,      // read port 1 address
   input  rf_pkg::rf_add_t              r2_add_i,      // read port 2 address
   output rf_pkg::rf_val_t              r1_val_o,
   output rf_pkg::rf_chk_t              r1_chk_o,
   output rf_pkg::rf_val_t              r2_val_o,
   output rf_pkg::rf_chk_t              r2_chk_o,
   input  wire                          upset_en_i,    // flip bits in one entry
   input  rf_pkg::rf_add_t              upset_add_i,   // entry to disturb
   input  wire  [rf_pkg::CW_W-1:0]      upset_mask_i   // [31:0] data, [38:32] checksum
);

   logic [rf_pkg::CW_W-1:0] mem [rf_pkg::RF_DEPTH];    // no reset, contents written first
   logic [rf_pkg::CW_W-1:0] r1_word;
   logic [rf_pkg::CW_W-1:0] r2_word;
   logic                    upset_hit_w;               // upset lands on the written entry

   assign upset_hit_w = we_i && (w_add_i == upset_add_i);

   always_ff @(posedge s_clk_i) begin
      // single-event upset model, a same-cycle write overrides it
      if (upset_en_i && !upset_hit_w) begin
         mem[upset_add_i] <= mem[upset_add_i] ^ upset_mask_i;
      end
      if (we_i) begin
         mem[w_add_i] <= {w_chk_i, w_val_i};           // data and checksum stored together
      end
   end

   // reads are asynchronous, the decoders sit right behind them
   assign r1_word = mem[r1_add_i];
   assign r2_word = mem[r2_add_i];

   assign r1_val_o = r1_word[rf_pkg::DATA_W-1:0];
   assign r1_chk_o = r1_word[rf_pkg::CW_W-1:rf_pkg::DATA_W];
   assign r2_val_o = r2_word[rf_pkg::DATA_W-1:0];
   assign r2_chk_o = r2_word[rf_pkg::CW_W-1:rf_pkg::DATA_W];

endmodule

`default_nettype wire

/* regfile/acm_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// automatic correction mechanism
// qualifies decoder flags, books one repair and shares the write port with writeback
module acm_ctrl #(
   parameter int NUM_FWD_STAGES = 3                    // in-flight destination stages
) (
   input  wire                                    s_clk_i,
   input  wire                                    rst_n_i,
   input  rf_pkg::rf_add_t                        r1_add_i,   // read port 1 address
   input  rf_pkg::rf_add_t                        r2_add_i,   // read port 2 address
   input  wire                                    r1_ce_i,    // raw decoder flags
   input  wire                                    r1_uce_i,
   input  wire                                    r2_ce_i,
   input  wire                                    r2_uce_i,
   input  rf_pkg::rf_val_t                        r1_dec_i,   // corrected read values
   input  rf_pkg::rf_val_t                        r2_dec_i,
   input  wire  [NUM_FWD_STAGES-1:0]              fwd_we_i,   // stage writes a register
   input  rf_pkg::rf_add_t [NUM_FWD_STAGES-1:0]   fwd_add_i,  // stage destination, 0 = wb
   input  wire                                    wb_we_i,    // writeback always writes
   input  rf_pkg::rf_add_t                        wb_add_i,
   input  rf_pkg::rf_val_t                        wb_val_i,
   output rf_pkg::rp_info_t                       ce_o,       // qualified correctable
   output rf_pkg::rp_info_t                       uce_o,      // qualified uncorrectable
   output logic                                   we_o,       // storage write port
   output rf_pkg::rf_add_t                        w_add_o,
   output rf_pkg::rf_val_t                        w_val_o
);

   rf_pkg::rp_info_t valid_err;   // port is not reading x0
   rf_pkg::rp_info_t fwd_hit;     // port address will be overwritten by a pipeline stage
   rf_pkg::rp_info_t rep_req;     // port asks for a repair
   logic             new_req;
   rf_pkg::rf_add_t  new_add;
   rf_pkg::rf_val_t  new_val;
   logic             rep_vld;     // pending repair
   rf_pkg::rf_add_t  rep_add;
   rf_pkg::rf_val_t  rep_val;
   logic             rep_hold;    // writeback owns the port this cycle

   // x0 is never consumed, faults there are ignored
   assign valid_err = {r2_add_i != '0, r1_add_i != '0};

   always_comb begin
      fwd_hit = '0;
      for (int s = 0; s < NUM_FWD_STAGES; s++) begin
         if (fwd_we_i[s] && (fwd_add_i[s] == r1_add_i)) fwd_hit[0] = 1'b1;
         if (fwd_we_i[s] && (fwd_add_i[s] == r2_add_i)) fwd_hit[1] = 1'b1;
      end
   end

   assign uce_o = {r2_uce_i, r1_uce_i} & valid_err;
   // a value that gets forwarded and rewritten needs no report or repair
   assign ce_o  = {r2_ce_i, r1_ce_i} & valid_err & ~fwd_hit;

   // skip ports whose register is being written right now, the write fixes it
   assign rep_req[0] = ce_o[0] & ~(we_o && (w_add_o == r1_add_i));
   assign rep_req[1] = ce_o[1] & ~(we_o && (w_add_o == r2_add_i));

   assign new_req = |rep_req;
   assign new_add = rep_req[1] ? r2_add_i : r1_add_i;   // port 2 wins
   assign new_val = rep_req[1] ? r2_dec_i : r1_dec_i;

   assign rep_hold = rep_vld & wb_we_i;

   always_ff @(posedge s_clk_i) begin
      if (!rst_n_i) begin
         rep_vld <= 1'b0;
      end else if (rep_hold) begin
         rep_vld <= (wb_add_i != rep_add);               // defer, or drop if overwritten
      end else begin
         rep_vld <= new_req;                              // fired or idle, take new one
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (!rep_hold) begin
         rep_add <= new_add;
         rep_val <= new_val;
      end
   end

   // writeback always has the port, repair fills idle cycles
   assign we_o    = wb_we_i | rep_vld;
   assign w_add_o = wb_we_i ? wb_add_i : rep_add;
   assign w_val_o = wb_we_i ? wb_val_i : rep_val;

   // no stale request survives reset
   a_rep_reset : assert property (@(posedge s_clk_i) !rst_n_i |=> !rep_vld)
      else $error("acm_ctrl: repair pending after reset");

   // a repair that meets writeback to another register is not written, it waits unchanged
   a_rep_no_wb : assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      rep_vld && wb_we_i && (wb_add_i != rep_add)
      |=> rep_vld && $stable(rep_add) && $stable(rep_val))
      else $error("acm_ctrl: repair written or lost while writeback held the port");

endmodule

`default_nettype wire

/* source/ecc_regfile_top.sv */
`timescale 1ns/1ps
`default_nettype none

// SEC-DED register file, 32 x 32 bit, two read ports, one write port
module ecc_regfile_top #(
   parameter int NUM_FWD_STAGES = 3                    // execute, memory, writeback
) (
   input  wire                                    s_clk_i,
   input  wire                                    rst_n_i,
   input  rf_pkg::rf_add_t                        rd1_add_i,
   input  rf_pkg::rf_add_t                        rd2_add_i,
   output rf_pkg::rf_val_t                        rd1_val_o,  // corrected operand 1
   output rf_pkg::rf_val_t                        rd2_val_o,  // corrected operand 2
   input  wire                                    wb_we_i,
   input  rf_pkg::rf_add_t                        wb_add_i,
   input  rf_pkg::rf_val_t                        wb_val_i,
   input  wire  [NUM_FWD_STAGES-1:0]              fwd_we_i,
   input  rf_pkg::rf_add_t [NUM_FWD_STAGES-1:0]   fwd_add_i,
   output rf_pkg::rp_info_t                       ce_o,
   output rf_pkg::rp_info_t                       uce_o,
   input  wire                                    upset_en_i,
   input  rf_pkg::rf_add_t                        upset_add_i,
   input  wire  [rf_pkg::CW_W-1:0]                upset_mask_i
);

   rf_pkg::rf_val_t r1_raw, r2_raw;     // stored data as read
   rf_pkg::rf_chk_t r1_chk, r2_chk;     // stored checksums
   rf_pkg::rf_val_t r1_dec, r2_dec;     // decoded data
   logic            r1_ce, r1_uce, r2_ce, r2_uce;
   logic            we;                 // arbitrated write port
   rf_pkg::rf_add_t w_add;
   rf_pkg::rf_val_t w_val;
   rf_pkg::rf_chk_t w_chk;

   rf_data_array u_rf_data_array (
      .s_clk_i, .we_i(we), .w_add_i(w_add), .w_val_i(w_val), .w_chk_i(w_chk),
      .r1_add_i(rd1_add_i), .r2_add_i(rd2_add_i),
      .r1_val_o(r1_raw), .r1_chk_o(r1_chk), .r2_val_o(r2_raw), .r2_chk_o(r2_chk),
      .upset_en_i, .upset_add_i, .upset_mask_i
   );

   // checksum is formed on whatever wins the write port
   secded_encode u_secded_encode (.data_i(w_val), .chk_o(w_chk));

   secded_decode u_secded_decode_r1 (
      .data_i(r1_raw), .chk_i(r1_chk), .data_o(r1_dec), .ce_o(r1_ce), .uce_o(r1_uce)
   );
   secded_decode u_secded_decode_r2 (
      .data_i(r2_raw), .chk_i(r2_chk), .data_o(r2_dec), .ce_o(r2_ce), .uce_o(r2_uce)
   );

   acm_ctrl #(.NUM_FWD_STAGES(NUM_FWD_STAGES)) u_acm_ctrl (
      .s_clk_i, .rst_n_i, .r1_add_i(rd1_add_i), .r2_add_i(rd2_add_i),
      .r1_ce_i(r1_ce), .r1_uce_i(r1_uce), .r2_ce_i(r2_ce), .r2_uce_i(r2_uce),
      .r1_dec_i(r1_dec), .r2_dec_i(r2_dec), .fwd_we_i, .fwd_add_i,
      .wb_we_i, .wb_add_i, .wb_val_i, .ce_o, .uce_o,
      .we_o(we), .w_add_o(w_add), .w_val_o(w_val)
   );

   assign rd1_val_o = r1_dec;           // operands leave already corrected
   assign rd2_val_o = r2_dec;

endmodule

`default_nettype wire

/* tests/tb_ecc_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ecc_regfile;

   localparam int NUM_FWD    = 3;                       // execute, memory, writeback
   localparam int CLK_PERIOD = 40;                      // ns
   localparam int DRV_DLY    = 2;                       // inputs move this long after the edge
   // cycles per test: reset, random rw, single, double, x0, forwarding, writeback race
   localparam int RUN_CYCLES = 8 + 80 + 8 + 8 + 11 + 8 + 12;

   logic                            s_clk_i;
   logic                            rst_n_i;
   rf_pkg::rf_add_t                 rd1_add_i;
   rf_pkg::rf_add_t                 rd2_add_i;
   rf_pkg::rf_val_t                 rd1_val_o;
   rf_pkg::rf_val_t                 rd2_val_o;
   logic                            wb_we_i;
   rf_pkg::rf_add_t                 wb_add_i;
   rf_pkg::rf_val_t                 wb_val_i;
   logic [NUM_FWD-1:0]              fwd_we_i;
   rf_pkg::rf_add_t [NUM_FWD-1:0]   fwd_add_i;
   rf_pkg::rp_info_t                ce_o;
   rf_pkg::rp_info_t                uce_o;
   logic                            upset_en_i;
   rf_pkg::rf_add_t                 upset_add_i;
   logic [rf_pkg::CW_W-1:0]         upset_mask_i;

   rf_pkg::rf_val_t  shadow [rf_pkg::RF_DEPTH];         // last value written per register
   logic [1:0]       fault  [rf_pkg::RF_DEPTH];         // 0 clean, 1 one flip, 2 two flips
   logic             chk_en;                            // model holds every register
   int               err_cnt, err_mark, test_cnt, test_fail;

   rf_pkg::rf_val_t  exp_val1, exp_val2;
   logic             chk_val1, chk_val2;                // value is trustworthy on that port
   rf_pkg::rp_info_t exp_ce, exp_uce;
   rf_pkg::rp_info_t fwd_hit;                           // port register still in flight

   ecc_regfile_top #(.NUM_FWD_STAGES(NUM_FWD)) u_ecc_regfile_top (.*);

   initial begin
      s_clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) s_clk_i = ~s_clk_i;
   end

   // expected outputs straight from the model
   always_comb begin
      fwd_hit = '0;
      for (int s = 0; s < NUM_FWD; s++) begin
         if (fwd_we_i[s] && fwd_add_i[s] == rd1_add_i) fwd_hit[0] = 1'b1;
         if (fwd_we_i[s] && fwd_add_i[s] == rd2_add_i) fwd_hit[1] = 1'b1;
      end
      exp_val1   = shadow[rd1_add_i];
      exp_val2   = shadow[rd2_add_i];
      chk_val1   = chk_en && fault[rd1_add_i] != 2'd2;   // double flips are not correctable
      chk_val2   = chk_en && fault[rd2_add_i] != 2'd2;
      exp_uce[0] = rd1_add_i != '0 && fault[rd1_add_i] == 2'd2;
      exp_uce[1] = rd2_add_i != '0 && fault[rd2_add_i] == 2'd2;
      exp_ce[0]  = rd1_add_i != '0 && fault[rd1_add_i] == 2'd1 && !fwd_hit[0];
      exp_ce[1]  = rd2_add_i != '0 && fault[rd2_add_i] == 2'd1 && !fwd_hit[1];
   end

   a_rd1_val : assert property (@(posedge s_clk_i) chk_val1 |-> rd1_val_o == exp_val1)
      else begin
         $display("FAIL t=%0t rd1_val_o exp=%h act=%h", $time, $sampled(exp_val1),
                  $sampled(rd1_val_o));
         err_cnt++;
      end
   a_rd2_val : assert property (@(posedge s_clk_i) chk_val2 |-> rd2_val_o == exp_val2)
      else begin
         $display("FAIL t=%0t rd2_val_o exp=%h act=%h", $time, $sampled(exp_val2),
                  $sampled(rd2_val_o));
         err_cnt++;
      end
   a_ce : assert property (@(posedge s_clk_i) chk_en |-> ce_o == exp_ce)
      else begin
         $display("FAIL t=%0t ce_o exp=%b act=%b", $time, $sampled(exp_ce), $sampled(ce_o));
         err_cnt++;
      end
   a_uce : assert property (@(posedge s_clk_i) chk_en |-> uce_o == exp_uce)
      else begin
         $display("FAIL t=%0t uce_o exp=%b act=%b", $time, $sampled(exp_uce), $sampled(uce_o));
         err_cnt++;
      end

   task automatic tick();
      @(posedge s_clk_i);
      #DRV_DLY;
   endtask

   task automatic hold(input int n);
      repeat (n) tick();
   endtask

   // writeback write, stage 0 of the in-flight list mirrors it
   task automatic write_reg(input rf_pkg::rf_add_t a, input rf_pkg::rf_val_t v);
      wb_we_i      = 1'b1;
      wb_add_i     = a;
      wb_val_i     = v;
      fwd_we_i[0]  = 1'b1;
      fwd_add_i[0] = a;
      tick();
      shadow[a]    = v;                                 // readable from here on
      fault[a]     = 2'd0;
      wb_we_i      = 1'b0;
      fwd_we_i[0]  = 1'b0;
   endtask

   task automatic inject(input rf_pkg::rf_add_t a, input logic [rf_pkg::CW_W-1:0] mask);
      upset_en_i   = 1'b1;
      upset_add_i  = a;
      upset_mask_i = mask;
      tick();
      upset_en_i   = 1'b0;
      fault[a]     = ($countones(mask) == 1) ? 2'd1 : 2'd2;
   endtask

   // detect edge, repair edge, then a clean re-read
   task automatic await_repair(input rf_pkg::rf_add_t a);
      hold(2);
      fault[a] = 2'd0;
      tick();
   endtask

   function automatic logic [rf_pkg::CW_W-1:0] bit_mask(input int b);
      logic [rf_pkg::CW_W-1:0] m;
      m    = '0;
      m[b] = 1'b1;
      return m;
   endfunction

   function automatic rf_pkg::rf_add_t pick_reg();
      return rf_pkg::rf_add_t'($urandom_range(31, 1));  // never x0
   endfunction

   function automatic rf_pkg::rf_add_t other_reg(input rf_pkg::rf_add_t a);
      return rf_pkg::rf_add_t'((int'(a) % 31) + 1);
   endfunction

   task automatic close_test(input string name);
      test_cnt++;
      if (err_cnt == err_mark) begin
         $display("PASS %s", name);
      end else begin
         $display("FAIL %s with %0d wrong check(s)", name, err_cnt - err_mark);
         test_fail++;
      end
      err_mark = err_cnt;
   endtask

   initial begin
      #((2 * RUN_CYCLES + 20) * CLK_PERIOD);
      $display("watchdog expired, run still busy after %0d cycles", 2 * RUN_CYCLES + 20);
      $display("Test failed");
      $finish;
   end

   initial begin
      rf_pkg::rf_add_t r;
      rf_pkg::rf_add_t q;
      int              b0;
      void'($urandom(32'h5cbd));
      err_cnt      = 0;
      err_mark     = 0;
      test_cnt     = 0;
      test_fail    = 0;
      chk_en       = 1'b0;
      rst_n_i      = 1'b0;
      rd1_add_i    = '0;                                // x0 hides garbage before the writes
      rd2_add_i    = '0;
      wb_we_i      = 1'b0;
      wb_add_i     = '0;
      wb_val_i     = '0;
      fwd_we_i     = '0;
      fwd_add_i    = '0;
      upset_en_i   = 1'b0;
      upset_add_i  = '0;
      upset_mask_i = '0;
      repeat (8) @(posedge s_clk_i);
      #DRV_DLY;
      rst_n_i = 1'b1;

      for (int i = 0; i < rf_pkg::RF_DEPTH; i++) write_reg(rf_pkg::rf_add_t'(i), $urandom());
      chk_en = 1'b1;
      for (int i = 0; i < rf_pkg::RF_DEPTH; i++) begin
         rd1_add_i = rf_pkg::rf_add_t'(i);
         rd2_add_i = rf_pkg::rf_add_t'(31 - i);
         tick();
      end
      repeat (16) begin
         rd1_add_i = rf_pkg::rf_add_t'($urandom_range(31, 0));
         rd2_add_i = rf_pkg::rf_add_t'($urandom_range(31, 0));
         tick();
      end
      close_test("random_rw");

      r = pick_reg();                                   // data bit on port 1
      rd1_add_i = r;
      rd2_add_i = other_reg(r);
      inject(r, bit_mask(int'($urandom_range(31, 0))));
      await_repair(r);
      r = pick_reg();                                   // checksum bit on port 2
      rd2_add_i = r;
      rd1_add_i = other_reg(r);
      inject(r, bit_mask(32 + int'($urandom_range(6, 0))));
      await_repair(r);
      close_test("single_upset");

      r  = pick_reg();
      b0 = int'($urandom_range(38, 0));
      rd1_add_i = r;
      rd2_add_i = other_reg(r);
      inject(r, bit_mask(b0) | bit_mask((b0 + 1 + int'($urandom_range(37, 0))) % 39));
      hold(5);                                          // uce stays up, no repair
      write_reg(r, $urandom());
      tick();
      close_test("double_upset");

      rd1_add_i = '0;
      rd2_add_i = '0;
      inject('0, bit_mask(int'($urandom_range(38, 0))));
      hold(3);
      write_reg('0, $urandom());
      inject('0, bit_mask(3) | bit_mask(35));
      hold(3);
      write_reg('0, $urandom());
      tick();
      close_test("x0_upset");

      r = pick_reg();
      rd1_add_i    = r;
      rd2_add_i    = other_reg(r);
      fwd_we_i[2]  = 1'b1;                              // execute stage targets r
      fwd_add_i[2] = r;
      inject(r, bit_mask(int'($urandom_range(38, 0))));
      hold(4);
      fwd_we_i[2]  = 1'b0;
      await_repair(r);                                  // first edge shows the error kept
      close_test("fwd_masked");

      r = pick_reg();
      q = other_reg(r);
      rd1_add_i = r;
      rd2_add_i = q;
      inject(r, bit_mask(int'($urandom_range(38, 0))));
      tick();                                           // repair booked here
      write_reg(r, $urandom());                         // same edge the repair wanted
      hold(3);
      inject(r, bit_mask(int'($urandom_range(38, 0))));
      tick();
      write_reg(q, $urandom());                         // other register, repair waits
      tick();
      fault[r] = 2'd0;
      hold(2);
      close_test("wb_vs_repair");

      $display("summary: %0d tests run, %0d bad, %0d check errors", test_cnt, test_fail,
               err_cnt);
      if (err_cnt == 0 && test_fail == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
common/rf_pkg.sv
source/secded_encode.sv
source/secded_decode.sv
regfile/rf_data_array.sv
regfile/acm_ctrl.sv
source/ecc_regfile_top.sv
tests/tb_ecc_regfile.sv

/* run.sh */
#!/bin/sh
# build and run the ECC register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_ecc_regfile -f sources.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
   exit 0
fi
exit 1
